// ==== alu_path.sv ====
`timescale 1ns/100ps

module alu_path (
	input riscv_pkg::word_t ex_rs1_val,
	input riscv_pkg::word_t ex_rs2_val,
	input riscv_pkg::word_t ex_imm,
	input riscv_pkg::reg_idx_t ex_rs1,
	input riscv_pkg::reg_idx_t ex_rs2,
	input riscv_pkg::alu_op_t ex_alu_op,
	input logic ex_use_imm,
	input riscv_pkg::reg_idx_t mem_rd,
	input logic mem_reg_write,
	input riscv_pkg::word_t mem_fwd_val,
	input riscv_pkg::reg_idx_t wb_rd,
	input logic wb_reg_write,
	input riscv_pkg::word_t wb_val,
	output riscv_pkg::word_t fwd_a,
	output riscv_pkg::word_t fwd_b,
	output riscv_pkg::word_t alu_result
);

	riscv_pkg::word_t op_b;

	// newest producer wins and x0 is never forwarded
	function automatic riscv_pkg::word_t fwd_sel(input riscv_pkg::reg_idx_t rs,
		input riscv_pkg::word_t rf_val);
		if (mem_reg_write && mem_rd != '0 && mem_rd == rs)
			return mem_fwd_val;
		else if (wb_reg_write && wb_rd != '0 && wb_rd == rs)
			return wb_val;
		else
			return rf_val;
	endfunction

	always_comb begin
		fwd_a = fwd_sel(ex_rs1, ex_rs1_val);
		fwd_b = fwd_sel(ex_rs2, ex_rs2_val); // also store data and compare operand
	end

	assign op_b = ex_use_imm ? ex_imm : fwd_b;

	always_comb begin
		case (ex_alu_op)
			riscv_pkg::alu_add: alu_result = fwd_a + op_b;
			riscv_pkg::alu_sub: alu_result = fwd_a - op_b;
			riscv_pkg::alu_and: alu_result = fwd_a & op_b;
			riscv_pkg::alu_or:  alu_result = fwd_a | op_b;
			riscv_pkg::alu_xor: alu_result = fwd_a ^ op_b;
			riscv_pkg::alu_sll: alu_result = fwd_a << op_b[4:0];
			riscv_pkg::alu_srl: alu_result = fwd_a >> op_b[4:0];
			riscv_pkg::alu_slt: alu_result = {31'b0, $signed(fwd_a) < $signed(op_b)};
			default: alu_result = fwd_a + op_b;
		endcase
	end

endmodule

// ==== branch_path.sv ====
`timescale 1ns/100ps

module branch_path #(
	parameter int ADDR_W = 12
) (
	input logic [ADDR_W-1:0] ex_pc,
	input riscv_pkg::word_t ex_imm,
	input riscv_pkg::word_t fwd_a,
	input riscv_pkg::word_t fwd_b,
	input logic ex_branch,
	input logic ex_branch_ne,
	input logic ex_jump,
	input logic ex_valid,
	output logic take,
	output logic [ADDR_W-1:0] target,
	output riscv_pkg::word_t link_val
);

	logic eq;
	logic [ADDR_W-1:0] pc_plus4;

	assign eq = (fwd_a == fwd_b);

	// beq on equal, bne on not equal, jal always
	assign take = ex_valid && (ex_jump || (ex_branch && (eq ^ ex_branch_ne)));

	assign target = ex_pc + ex_imm[ADDR_W-1:0]; // upper immediate bits fall outside memory
	assign pc_plus4 = ex_pc + ADDR_W'(4);
	assign link_val = riscv_pkg::word_t'(pc_plus4);

endmodule

// ==== decode_ctrl.sv ====
`timescale 1ns/100ps

module decode_ctrl #(
	parameter int ADDR_W = 12
) (
	input logic CLK,
	input logic RSTn,
	input logic redirect,
	input riscv_pkg::word_t if_instr,
	input logic [ADDR_W-1:0] if_pc,
	input logic if_valid,
	input riscv_pkg::word_t rf_rd1,
	input riscv_pkg::word_t rf_rd2,
	output riscv_pkg::reg_idx_t rf_ra1,
	output riscv_pkg::reg_idx_t rf_ra2,
	output riscv_pkg::word_t ex_rs1_val,
	output riscv_pkg::word_t ex_rs2_val,
	output riscv_pkg::word_t ex_imm,
	output logic [ADDR_W-1:0] ex_pc,
	output riscv_pkg::reg_idx_t ex_rs1,
	output riscv_pkg::reg_idx_t ex_rs2,
	output riscv_pkg::reg_idx_t ex_rd,
	output riscv_pkg::alu_op_t ex_alu_op,
	output logic ex_use_imm,
	output logic ex_reg_write,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_branch,
	output logic ex_branch_ne,
	output logic ex_jump,
	output logic ex_halt,
	output logic ex_valid
);

	riscv_pkg::opc_t opc;
	logic [2:0] funct3;
	riscv_pkg::word_t imm_i, imm_s, imm_b, imm_j, imm;
	riscv_pkg::alu_op_t alu_op;
	logic known, use_imm, reg_write, mem_read, mem_write;
	logic branch, jump, halt_c, dec_valid;

	// funct3 to alu op, alt picks sub for r-type
	function automatic riscv_pkg::alu_op_t f3_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? riscv_pkg::alu_sub : riscv_pkg::alu_add;
			3'b001: return riscv_pkg::alu_sll;
			3'b010: return riscv_pkg::alu_slt;
			3'b100: return riscv_pkg::alu_xor;
			3'b101: return riscv_pkg::alu_srl;
			3'b110: return riscv_pkg::alu_or;
			3'b111: return riscv_pkg::alu_and;
			default: return riscv_pkg::alu_add;
		endcase
	endfunction

	assign opc = if_instr[6:0];
	assign funct3 = if_instr[14:12];
	assign rf_ra1 = if_instr[19:15];
	assign rf_ra2 = if_instr[24:20];

	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
		if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
		if_instr[30:21], 1'b0};

	always_comb begin
		known = 1'b0;
		use_imm = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		halt_c = 1'b0;
		alu_op = riscv_pkg::alu_add; // address adds use this too
		imm = imm_i;
		case (opc)
			riscv_pkg::opc_op: begin
				known = 1'b1;
				reg_write = 1'b1;
				alu_op = f3_op(funct3, if_instr[30]);
			end
			riscv_pkg::opc_op_imm: begin
				known = 1'b1;
				reg_write = 1'b1;
				use_imm = 1'b1;
				alu_op = f3_op(funct3, 1'b0); // bit 30 is immediate here
			end
			riscv_pkg::opc_load: begin
				known = 1'b1;
				reg_write = 1'b1;
				use_imm = 1'b1;
				mem_read = 1'b1;
			end
			riscv_pkg::opc_store: begin
				known = 1'b1;
				use_imm = 1'b1;
				mem_write = 1'b1;
				imm = imm_s;
			end
			riscv_pkg::opc_branch: begin
				known = 1'b1;
				branch = 1'b1;
				imm = imm_b;
			end
			riscv_pkg::opc_jal: begin
				known = 1'b1;
				reg_write = 1'b1;
				jump = 1'b1;
				imm = imm_j;
			end
			riscv_pkg::opc_system: begin
				known = (if_instr == riscv_pkg::ebreak_word);
				halt_c = known;
			end
			default: ;
		endcase
	end

	// unknown opcodes and squashed slots become bubbles
	assign dec_valid = if_valid && known && !redirect;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			ex_valid <= 1'b0;
			ex_use_imm <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_branch <= 1'b0;
			ex_branch_ne <= 1'b0;
			ex_jump <= 1'b0;
			ex_halt <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
			ex_use_imm <= dec_valid && use_imm;
			ex_reg_write <= dec_valid && reg_write;
			ex_mem_read <= dec_valid && mem_read;
			ex_mem_write <= dec_valid && mem_write;
			ex_branch <= dec_valid && branch;
			ex_branch_ne <= dec_valid && branch && funct3[0]; // bne
			ex_jump <= dec_valid && jump;
			ex_halt <= dec_valid && halt_c;
		end
	end

	always_ff @(posedge CLK) begin
		ex_rs1_val <= rf_rd1;
		ex_rs2_val <= rf_rd2;
		ex_imm <= imm;
		ex_pc <= if_pc;
		ex_rs1 <= rf_ra1;
		ex_rs2 <= rf_ra2;
		ex_rd <= if_instr[11:7];
		ex_alu_op <= alu_op;
	end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage #(
	parameter int ADDR_W = 12
) (
	input logic CLK,
	input logic RSTn,
	input logic redirect,
	input logic [ADDR_W-1:0] redirect_pc,
	input logic halt,
	input riscv_pkg::word_t i_mem_di,
	output logic [ADDR_W-1:0] i_mem_addr,
	output logic i_mem_csn,
	output riscv_pkg::word_t if_instr,
	output logic [ADDR_W-1:0] if_pc,
	output logic if_valid
);

	logic [ADDR_W-1:0] pc;

	assign i_mem_addr = pc;
	assign i_mem_csn = halt; // no more fetches once stopped

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
		end else if (!halt) begin
			pc <= redirect ? redirect_pc : pc + ADDR_W'(4);
		end
	end

	// if/id register
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			if_valid <= 1'b0;
		end else begin
			if_valid <= !redirect && !halt; // squash on taken branch
		end
	end

	always_ff @(posedge CLK) begin
		if_instr <= i_mem_di;
		if_pc <= pc;
	end

endmodule

// ==== files.f ====
riscv_pkg.sv
fetch_stage.sv
decode_ctrl.sv
alu_path.sv
branch_path.sv
mem_wb_pipe.sv
riscv_top.sv
riscv_checker.sv
tb_riscv.sv

// ==== mem_wb_pipe.sv ====
`timescale 1ns/100ps

module mem_wb_pipe #(
	parameter int ADDR_W = 12
) (
	input logic CLK,
	input logic RSTn,
	input riscv_pkg::word_t alu_result,
	input riscv_pkg::word_t link_val,
	input riscv_pkg::word_t fwd_b,
	input logic take,
	input logic [ADDR_W-1:0] target,
	input riscv_pkg::reg_idx_t ex_rd,
	input logic ex_reg_write,
	input logic ex_mem_read,
	input logic ex_mem_write,
	input logic ex_jump,
	input logic ex_halt,
	input logic ex_valid,
	input riscv_pkg::word_t d_mem_di,
	output logic redirect,
	output logic [ADDR_W-1:0] redirect_pc,
	output logic [ADDR_W-1:0] d_mem_addr,
	output riscv_pkg::word_t d_mem_dout,
	output logic d_mem_csn,
	output logic d_mem_wen,
	output riscv_pkg::reg_idx_t mem_rd,
	output logic mem_reg_write,
	output riscv_pkg::word_t mem_fwd_val,
	output riscv_pkg::reg_idx_t wb_rd,
	output logic wb_reg_write,
	output riscv_pkg::word_t wb_val,
	output logic rf_we,
	output riscv_pkg::reg_idx_t rf_wa1,
	output riscv_pkg::word_t rf_wd,
	output logic halt,
	output riscv_pkg::word_t num_inst
);

	riscv_pkg::word_t ex_result, mem_result, mem_store;
	logic mem_valid, mem_read, mem_write, mem_halt;
	logic wb_valid, wb_halt, halt_r;
	logic draining, capture;

	// ebreak in mem or later, everything behind it is dropped
	assign draining = mem_halt || halt;
	assign capture = ex_valid && !draining;

	assign ex_result = ex_jump ? link_val : alu_result;
	assign redirect = take && !draining;
	assign redirect_pc = target;

	// ex/mem register
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			mem_valid <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			mem_halt <= 1'b0;
		end else begin
			mem_valid <= capture;
			mem_reg_write <= capture && ex_reg_write;
			mem_read <= capture && ex_mem_read;
			mem_write <= capture && ex_mem_write;
			mem_halt <= capture && ex_halt;
		end
	end

	always_ff @(posedge CLK) begin
		mem_result <= ex_result;
		mem_store <= fwd_b;
		mem_rd <= ex_rd;
	end

	assign d_mem_addr = mem_result[ADDR_W-1:0];
	assign d_mem_dout = mem_store;
	assign d_mem_csn = !(mem_read || mem_write);
	assign d_mem_wen = !mem_write; // active low
	assign mem_fwd_val = mem_result; // load data not ready yet

	// mem/wb register
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wb_valid <= 1'b0;
			wb_reg_write <= 1'b0;
			wb_halt <= 1'b0;
		end else begin
			wb_valid <= mem_valid;
			wb_reg_write <= mem_reg_write;
			wb_halt <= mem_halt;
		end
	end

	always_ff @(posedge CLK) begin
		wb_val <= mem_read ? d_mem_di : mem_result;
		wb_rd <= mem_rd;
	end

	assign halt = halt_r || wb_halt;
	assign rf_we = wb_reg_write && !halt_r;
	assign rf_wa1 = wb_rd;
	assign rf_wd = wb_val;

	// sticky halt and retire count
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			halt_r <= 1'b0;
			num_inst <= '0;
		end else begin
			halt_r <= halt;
			if (wb_valid && !wb_halt && !halt_r)
				num_inst <= num_inst + 32'd1;
		end
	end

endmodule

// ==== riscv_checker.sv ====
`timescale 1ns/100ps

module riscv_checker (
	input logic CLK,
	input logic RSTn,
	input logic rf_we,
	input logic halt,
	input logic d_mem_wen,
	input logic d_mem_csn
);

	// halt is sticky outside reset
	halt_sticky: assert property (@(posedge CLK)
		(!RSTn && $past(!RSTn) && $past(halt)) |-> halt)
		else $error("halt dropped while the core was running");

	no_write_after_halt: assert property (@(posedge CLK)
		(!RSTn && $past(!RSTn) && $past(halt)) |-> !rf_we)
		else $error("register write after halt");

	// a write strobe always comes with a chip select
	wen_needs_csn: assert property (@(posedge CLK) !d_mem_wen |-> !d_mem_csn)
		else $error("data write without chip select");

	quiet_after_reset: assert property (@(posedge CLK)
		$fell(RSTn) |-> (!rf_we && !halt && d_mem_wen))
		else $error("activity in the first cycle after reset");

endmodule

bind riscv_top riscv_checker u_chk (
	.CLK(CLK), .RSTn(RSTn), .rf_we(rf_we), .halt(halt),
	.d_mem_wen(d_mem_wen), .d_mem_csn(d_mem_csn)
);

// ==== riscv_pkg.sv ====
package riscv_pkg;

	typedef logic [31:0] word_t; // data, instruction and operand width
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] alu_op_t;
	typedef logic [6:0] opc_t;

	// alu operation codes
	localparam alu_op_t alu_add = 4'd0;
	localparam alu_op_t alu_sub = 4'd1;
	localparam alu_op_t alu_and = 4'd2;
	localparam alu_op_t alu_or  = 4'd3;
	localparam alu_op_t alu_xor = 4'd4;
	localparam alu_op_t alu_sll = 4'd5;
	localparam alu_op_t alu_srl = 4'd6;
	localparam alu_op_t alu_slt = 4'd7; // signed compare

	// major opcodes of the supported subset
	localparam opc_t opc_op     = 7'b0110011; // r-type
	localparam opc_t opc_op_imm = 7'b0010011;
	localparam opc_t opc_load   = 7'b0000011;
	localparam opc_t opc_store  = 7'b0100011;
	localparam opc_t opc_branch = 7'b1100011;
	localparam opc_t opc_jal    = 7'b1101111;
	localparam opc_t opc_system = 7'b1110011;

	// only system instruction decoded, stops the core
	localparam word_t ebreak_word = 32'h0010_0073;

endpackage

// ==== riscv_top.sv ====
`timescale 1ns/100ps

module riscv_top #(
	parameter int ADDR_W = 12
) (
	input logic CLK,
	input logic RSTn,
	// instruction memory
	output logic i_mem_csn,
	input riscv_pkg::word_t i_mem_di,
	output logic [ADDR_W-1:0] i_mem_addr, // byte address
	// data memory
	output logic d_mem_csn,
	input riscv_pkg::word_t d_mem_di,
	output riscv_pkg::word_t d_mem_dout,
	output logic [ADDR_W-1:0] d_mem_addr, // byte address, word aligned
	output logic d_mem_wen,
	// register file
	output logic rf_we,
	output riscv_pkg::reg_idx_t rf_ra1,
	output riscv_pkg::reg_idx_t rf_ra2,
	output riscv_pkg::reg_idx_t rf_wa1,
	input riscv_pkg::word_t rf_rd1,
	input riscv_pkg::word_t rf_rd2,
	output riscv_pkg::word_t rf_wd,
	output logic halt,
	output riscv_pkg::word_t num_inst
);

	riscv_pkg::word_t if_instr, ex_rs1_val, ex_rs2_val, ex_imm;
	riscv_pkg::word_t fwd_a, fwd_b, alu_result, link_val, mem_fwd_val, wb_val;
	riscv_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
	riscv_pkg::alu_op_t ex_alu_op;
	logic [ADDR_W-1:0] if_pc, ex_pc, target, redirect_pc;
	logic if_valid, redirect, take;
	logic ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
	logic ex_branch, ex_branch_ne, ex_jump, ex_halt, ex_valid;
	logic mem_reg_write, wb_reg_write;

	fetch_stage #(.ADDR_W(ADDR_W)) u_fetch (
		.CLK(CLK), .RSTn(RSTn),
		.redirect(redirect), .redirect_pc(redirect_pc), .halt(halt),
		.i_mem_di(i_mem_di), .i_mem_addr(i_mem_addr), .i_mem_csn(i_mem_csn),
		.if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid)
	);

	decode_ctrl #(.ADDR_W(ADDR_W)) u_decode (
		.CLK(CLK), .RSTn(RSTn), .redirect(redirect),
		.if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid),
		.rf_rd1(rf_rd1), .rf_rd2(rf_rd2), .rf_ra1(rf_ra1), .rf_ra2(rf_ra2),
		.ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val), .ex_imm(ex_imm), .ex_pc(ex_pc),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_alu_op(ex_alu_op),
		.ex_use_imm(ex_use_imm), .ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
		.ex_branch(ex_branch), .ex_branch_ne(ex_branch_ne), .ex_jump(ex_jump),
		.ex_halt(ex_halt), .ex_valid(ex_valid)
	);

	alu_path u_alu (
		.ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val), .ex_imm(ex_imm),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
		.mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_fwd_val(mem_fwd_val),
		.wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_val(wb_val),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .alu_result(alu_result)
	);

	branch_path #(.ADDR_W(ADDR_W)) u_branch (
		.ex_pc(ex_pc), .ex_imm(ex_imm), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.ex_branch(ex_branch), .ex_branch_ne(ex_branch_ne), .ex_jump(ex_jump),
		.ex_valid(ex_valid),
		.take(take), .target(target), .link_val(link_val)
	);

	mem_wb_pipe #(.ADDR_W(ADDR_W)) u_mem_wb (
		.CLK(CLK), .RSTn(RSTn),
		.alu_result(alu_result), .link_val(link_val), .fwd_b(fwd_b),
		.take(take), .target(target), .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write), .ex_jump(ex_jump),
		.ex_halt(ex_halt), .ex_valid(ex_valid), .d_mem_di(d_mem_di),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.d_mem_addr(d_mem_addr), .d_mem_dout(d_mem_dout),
		.d_mem_csn(d_mem_csn), .d_mem_wen(d_mem_wen),
		.mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_fwd_val(mem_fwd_val),
		.wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_val(wb_val),
		.rf_we(rf_we), .rf_wa1(rf_wa1), .rf_wd(rf_wd),
		.halt(halt), .num_inst(num_inst)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert --top-module tb_riscv -f files.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log && ! grep -q "Regression failed" sim.log \
	|| { echo "simulation failed"; exit 1; }
echo "simulation ok"

// ==== tb_riscv.sv ====
`timescale 1ns/100ps

module tb_riscv;

	localparam int PERIOD = 40;
	localparam int SEED = 32'h9dde_00bd;
	localparam int DEPTH = 1024;
	localparam int CYCLE_LIMIT = 200;
	localparam int NUM_TESTS = 6;
	localparam longint WATCHDOG_NS = (NUM_TESTS * (CYCLE_LIMIT + 20) + 100) * PERIOD;

	logic CLK = 1'b0;
	logic RSTn = 1'b1;
	logic i_mem_csn, d_mem_csn, d_mem_wen, rf_we, halt;
	logic [11:0] i_mem_addr, d_mem_addr;
	riscv_pkg::word_t i_mem_di, d_mem_di, d_mem_dout, rf_rd1, rf_rd2, rf_wd, num_inst;
	riscv_pkg::reg_idx_t rf_ra1, rf_ra2, rf_wa1;

	riscv_pkg::word_t imem [DEPTH];
	riscv_pkg::word_t dmem [DEPTH];
	riscv_pkg::word_t regs [32];
	riscv_pkg::word_t e [32]; // expected register values
	int pc_idx;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	riscv_top #(.ADDR_W(12)) uut (
		.CLK(CLK), .RSTn(RSTn),
		.i_mem_csn(i_mem_csn), .i_mem_di(i_mem_di), .i_mem_addr(i_mem_addr),
		.d_mem_csn(d_mem_csn), .d_mem_di(d_mem_di), .d_mem_dout(d_mem_dout),
		.d_mem_addr(d_mem_addr), .d_mem_wen(d_mem_wen),
		.rf_we(rf_we), .rf_ra1(rf_ra1), .rf_ra2(rf_ra2), .rf_wa1(rf_wa1),
		.rf_rd1(rf_rd1), .rf_rd2(rf_rd2), .rf_wd(rf_wd),
		.halt(halt), .num_inst(num_inst)
	);

	always #(PERIOD / 2) CLK = ~CLK;

	// memory and register file models
	assign i_mem_di = imem[i_mem_addr[11:2]];
	assign d_mem_di = dmem[d_mem_addr[11:2]];
	assign rf_rd1 = (rf_ra1 == 5'd0) ? '0 : (rf_we && rf_wa1 == rf_ra1) ? rf_wd : regs[rf_ra1];
	assign rf_rd2 = (rf_ra2 == 5'd0) ? '0 : (rf_we && rf_wa1 == rf_ra2) ? rf_wd : regs[rf_ra2];

	always @(posedge CLK) begin
		if (!d_mem_csn && !d_mem_wen)
			dmem[d_mem_addr[11:2]] <= d_mem_dout;
		if (rf_we && rf_wa1 != 5'd0)
			regs[rf_wa1] <= rf_wd;
	end

	function automatic riscv_pkg::word_t r_instr(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, riscv_pkg::opc_op};
	endfunction

	function automatic riscv_pkg::word_t i_instr(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic riscv_pkg::word_t s_instr(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::opc_store};
	endfunction

	function automatic riscv_pkg::word_t b_instr(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input int off);
		logic [12:0] o;
		o = 13'(off);
		return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], riscv_pkg::opc_branch};
	endfunction

	function automatic riscv_pkg::word_t j_instr(input logic [4:0] rd, input int off);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], rd, riscv_pkg::opc_jal};
	endfunction

	task automatic emit(input riscv_pkg::word_t w);
		imem[pc_idx] = w;
		pc_idx++;
	endtask

	// opcode 7f is undecoded, so stray fetches become bubbles
	task automatic clear_models();
		for (int i = 0; i < DEPTH; i++) begin
			imem[i] = {i[9:0], 15'h0, 7'h7f};
			dmem[i] = 32'h5a00_0000 | 32'(i * 7 + 3);
		end
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
			e[i] = '0;
		end
		pc_idx = 0;
	endtask

	task automatic check_word(input string what, input riscv_pkg::word_t got,
		input riscv_pkg::word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_regs(input int first, input int last);
		for (int i = first; i <= last; i++)
			check_word($sformatf("x%0d", i), regs[i], e[i]);
	endtask

	task automatic apply_reset();
		@(posedge CLK);
		#2 RSTn = 1'b1;
		repeat (4) @(posedge CLK);
		#2 RSTn = 1'b0;
	endtask

	task automatic run_to_halt();
		int n;
		n = 0;
		while (!halt && n < CYCLE_LIMIT) begin
			@(posedge CLK);
			#2 n++;
		end
		checks++;
		assert (halt) else begin
			errors++;
			$display("core did not halt within %0d cycles", CYCLE_LIMIT);
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		$display("%s finished with %0d errors", name, errors - err_start);
	endtask

	task automatic reset_state();
		int err0;
		err0 = errors;
		clear_models();
		emit(riscv_pkg::ebreak_word);
		@(posedge CLK);
		#2 RSTn = 1'b1;
		repeat (2) @(posedge CLK);
		#2 check_word("rf_we in reset", 32'(rf_we), 0);
		check_word("d_mem_wen in reset", 32'(d_mem_wen), 1);
		check_word("d_mem_csn in reset", 32'(d_mem_csn), 1);
		check_word("halt in reset", 32'(halt), 0);
		check_word("num_inst in reset", num_inst, 0);
		repeat (2) @(posedge CLK);
		#2 RSTn = 1'b0;
		check_word("first i_mem_addr", 32'(i_mem_addr), 0);
		check_word("i_mem_csn after reset", 32'(i_mem_csn), 0);
		check_word("rf_we after reset", 32'(rf_we), 0);
		@(posedge CLK);
		#2 check_word("second i_mem_addr", 32'(i_mem_addr), 4);
		run_to_halt();
		check_word("num_inst for lone ebreak", num_inst, 0);
		end_test("reset_state", err0);
	endtask

	task automatic alu_chain();
		int err0;
		err0 = errors;
		clear_models();
		emit(i_instr(3'b000, 1, 0, 12'h123, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 2, 0, 12'hff9, riscv_pkg::opc_op_imm)); // -7
		emit(r_instr(7'h00, 3'b000, 3, 1, 2));
		emit(r_instr(7'h20, 3'b000, 4, 3, 1));
		emit(r_instr(7'h00, 3'b010, 5, 2, 1));
		emit(r_instr(7'h00, 3'b010, 6, 1, 2));
		emit(i_instr(3'b111, 7, 4, 12'h0f0, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 8, 0, 12'd5, riscv_pkg::opc_op_imm));
		emit(r_instr(7'h00, 3'b001, 9, 1, 8));
		emit(r_instr(7'h00, 3'b101, 10, 2, 8));
		emit(r_instr(7'h00, 3'b100, 11, 9, 10));
		emit(r_instr(7'h00, 3'b110, 12, 11, 3));
		emit(i_instr(3'b010, 13, 2, 12'hffd, riscv_pkg::opc_op_imm)); // slti -3
		emit(riscv_pkg::ebreak_word);
		e[1] = 32'h123;
		e[2] = 32'hffff_fff9;
		e[3] = e[1] + e[2];
		e[4] = e[3] - e[1];
		e[5] = ($signed(e[2]) < $signed(e[1])) ? 1 : 0;
		e[6] = ($signed(e[1]) < $signed(e[2])) ? 1 : 0;
		e[7] = e[4] & 32'h0f0;
		e[8] = 5;
		e[9] = e[1] << 5;
		e[10] = e[2] >> 5;
		e[11] = e[9] ^ e[10];
		e[12] = e[11] | e[3];
		e[13] = ($signed(e[2]) < -3) ? 1 : 0;
		apply_reset();
		run_to_halt();
		check_regs(1, 13);
		end_test("alu_chain", err0);
	endtask

	task automatic load_store();
		int err0;
		riscv_pkg::word_t spare;
		err0 = errors;
		clear_models();
		spare = dmem[17];
		emit(i_instr(3'b000, 1, 0, 12'h040, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 2, 0, 12'h7ab, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 3, 0, 12'd16, riscv_pkg::opc_op_imm));
		emit(r_instr(7'h00, 3'b001, 2, 2, 3));
		emit(i_instr(3'b100, 2, 2, 12'h5c3, riscv_pkg::opc_op_imm));
		emit(s_instr(2, 1, 12'd8));
		emit(i_instr(3'b010, 4, 1, 12'd8, riscv_pkg::opc_load));
		emit(i_instr(3'b000, 5, 0, 12'd1, riscv_pkg::opc_op_imm)); // load shadow
		emit(r_instr(7'h00, 3'b000, 6, 4, 4));
		emit(s_instr(4, 1, 12'hffc)); // offset -4
		emit(riscv_pkg::ebreak_word);
		e[1] = 32'h40;
		e[2] = (32'h7ab << 16) ^ 32'h5c3;
		e[3] = 16;
		e[4] = e[2];
		e[5] = 1;
		e[6] = e[4] + e[4];
		apply_reset();
		run_to_halt();
		check_regs(1, 6);
		check_word("dmem[0x48]", dmem[18], e[2]);
		check_word("dmem[0x3c]", dmem[15], e[2]);
		check_word("dmem[0x44] untouched", dmem[17], spare);
		end_test("load_store", err0);
	endtask

	task automatic control_flow();
		int err0;
		err0 = errors;
		clear_models();
		emit(i_instr(3'b000, 1, 0, 12'd5, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 2, 0, 12'd5, riscv_pkg::opc_op_imm));
		emit(b_instr(3'b000, 1, 2, 12)); // beq taken
		emit(i_instr(3'b000, 10, 0, 12'd1, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 11, 0, 12'd1, riscv_pkg::opc_op_imm));
		emit(b_instr(3'b001, 1, 2, 8)); // bne not taken
		emit(i_instr(3'b000, 12, 0, 12'd2, riscv_pkg::opc_op_imm));
		emit(b_instr(3'b000, 1, 12, 8)); // beq not taken
		emit(b_instr(3'b001, 1, 12, 12)); // bne taken
		emit(i_instr(3'b000, 13, 0, 12'd3, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 14, 0, 12'd3, riscv_pkg::opc_op_imm));
		emit(j_instr(15, 12));
		emit(i_instr(3'b000, 16, 0, 12'd4, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 17, 0, 12'd4, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 18, 15, 12'd1, riscv_pkg::opc_op_imm));
		emit(riscv_pkg::ebreak_word);
		e[1] = 5;
		e[2] = 5;
		e[12] = 2;
		e[15] = 11 * 4 + 4; // jal at word 11
		e[18] = e[15] + 1;
		apply_reset();
		run_to_halt();
		check_regs(1, 18);
		end_test("control_flow", err0);
	endtask

	task automatic halt_count();
		int err0;
		riscv_pkg::word_t word0;
		err0 = errors;
		clear_models();
		word0 = dmem[0];
		emit(i_instr(3'b000, 1, 0, 12'd1, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 2, 1, 12'd2, riscv_pkg::opc_op_imm));
		emit(b_instr(3'b000, 0, 0, 12));
		emit(i_instr(3'b000, 3, 0, 12'd9, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 4, 0, 12'd9, riscv_pkg::opc_op_imm));
		emit(r_instr(7'h00, 3'b000, 5, 1, 2));
		emit(riscv_pkg::ebreak_word);
		emit(i_instr(3'b000, 6, 0, 12'd7, riscv_pkg::opc_op_imm));
		emit(i_instr(3'b000, 7, 0, 12'd7, riscv_pkg::opc_op_imm));
		emit(s_instr(1, 0, 12'd0));
		e[1] = 1;
		e[2] = 3;
		e[5] = 4;
		apply_reset();
		run_to_halt();
		repeat (5) @(posedge CLK);
		#2 check_word("halt stays high", 32'(halt), 1);
		check_word("i_mem_csn after halt", 32'(i_mem_csn), 1);
		check_word("num_inst", num_inst, 4); // words 0, 1, 2 and 5
		check_regs(1, 7);
		check_word("dmem[0] after halt", dmem[0], word0);
		end_test("halt_count", err0);
	endtask

	task automatic random_imm();
		int err0;
		logic [11:0] imm;
		riscv_pkg::word_t simm, src;
		int rd, rs, op;
		err0 = errors;
		clear_models();
		rs = 0;
		for (int k = 0; k < 12; k++) begin
			imm = 12'($urandom());
			simm = {{20{imm[11]}}, imm};
			rd = 1 + k % 4;
			op = k % 3;
			src = (rs == 0) ? '0 : e[rs];
			case (op)
				0: begin
					emit(i_instr(3'b000, 5'(rd), 5'(rs), imm, riscv_pkg::opc_op_imm));
					e[rd] = src + simm;
				end
				1: begin
					emit(i_instr(3'b100, 5'(rd), 5'(rs), imm, riscv_pkg::opc_op_imm));
					e[rd] = src ^ simm;
				end
				default: begin
					emit(i_instr(3'b110, 5'(rd), 5'(rs), imm, riscv_pkg::opc_op_imm));
					e[rd] = src | simm;
				end
			endcase
			rs = rd;
		end
		emit(riscv_pkg::ebreak_word);
		apply_reset();
		run_to_halt();
		check_regs(1, 4);
		end_test("random_imm", err0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("Regression failed");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		reset_state();
		alu_chain();
		load_store();
		control_flow();
		halt_count();
		random_imm();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
